//--- Bender.yml
package:
  name: flitSwitch

sources:
  - files:
      - design/nocPkg.sv
      - design/flitQueue.sv
      - design/grantArbiter.sv
      - design/holdTimer.sv
      - design/outputMux.sv
      - design/flitSwitch.sv
  - target: test
    files:
      - tests/clockGen.sv
      - tests/flitSwitchTb.sv

//--- flitSwitch.f
design/nocPkg.sv
design/flitQueue.sv
design/grantArbiter.sv
design/holdTimer.sv
design/outputMux.sv
design/flitSwitch.sv
tests/clockGen.sv
tests/flitSwitchTb.sv

//--- tests/flitSwitchTb.sv
`timescale 1ns/10ps

module flitSwitchTb;

  localparam int queueDepth = 4;
  localparam int flitWidth = nocPkg::flitIdWidth + nocPkg::payloadWidth;
  localparam int tagWidth = nocPkg::payloadWidth - nocPkg::lengthWidth;

  logic clk;
  logic rst;
  logic [nocPkg::numPorts-1:0] inValid;
  logic [nocPkg::numPorts-1:0][nocPkg::flitIdWidth-1:0] inFlitId;
  logic [nocPkg::numPorts-1:0][nocPkg::payloadWidth-1:0] inPayload;
  logic [nocPkg::numPorts-1:0] inReady;
  logic outValid;
  logic [nocPkg::flitIdWidth-1:0] outFlitId;
  logic [nocPkg::payloadWidth-1:0] outPayload;
  logic outReady;

  logic [15:0] lfsr = 16'd72;
  logic [flitWidth-1:0] portFlits [nocPkg::numPorts][$]; // Flits per port in send order
  int pktLens [nocPkg::numPorts][$];
  logic [flitWidth-1:0] expQ [$];
  logic [flitWidth-1:0] expected;
  logic [nocPkg::lengthWidth-1:0] lastHeaderLen;
  logic [nocPkg::numPorts-1:0] sawFull;
  int expLen;
  int errors = 0;
  int errorsBefore = 0;
  int testCount = 0;
  int failedTests = 0;
  int flitsChecked = 0;
  int flitsSent = 0;
  int cycles = 0;

  clockGen u_clockGen (
    .clk (clk),
    .rst (rst)
  );

  flitSwitch #(
    .queueDepth (queueDepth)
  ) u_flitSwitch (
    .clk        (clk),
    .rst        (rst),
    .inValid    (inValid),
    .inFlitId   (inFlitId),
    .inPayload  (inPayload),
    .inReady    (inReady),
    .outValid   (outValid),
    .outFlitId  (outFlitId),
    .outPayload (outPayload),
    .outReady   (outReady)
  );

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic int unsigned randBits(input int n);
    int unsigned v;
    v = 0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsrNext(lfsr);
      v = (v << 1) | lfsr[0];
    end
    return v;
  endfunction

  function automatic void addPacket(input int p, input int len);
    portFlits[p].push_back({nocPkg::headerId, tagWidth'(randBits(tagWidth)),
                            nocPkg::lengthWidth'(len)});
    for (int i = 1; i < len; i++)
      portFlits[p].push_back({nocPkg::bodyId,
                              nocPkg::payloadWidth'(randBits(nocPkg::payloadWidth))});
    pktLens[p].push_back(len);
    flitsSent += len;
  endfunction

  // Whole packets go to the next requester after the last holder
  function automatic void predictOrder();
    int cur;
    int pick;
    int port;
    int pktNext [nocPkg::numPorts];
    int flitNext [nocPkg::numPorts];
    cur = nocPkg::portS; // Idle starts the search at L
    pick = 0;
    for (int p = 0; p < nocPkg::numPorts; p++)
    begin
      pktNext[p] = 0;
      flitNext[p] = 0;
    end
    while (pick >= 0)
    begin
      pick = -1;
      for (int k = 1; k <= nocPkg::numPorts; k++)
      begin
        port = (cur + k) % nocPkg::numPorts;
        if (pick < 0 && pktNext[port] < pktLens[port].size())
          pick = port;
      end
      if (pick >= 0)
      begin
        for (int f = 0; f < pktLens[pick][pktNext[pick]]; f++)
        begin
          expQ.push_back(portFlits[pick][flitNext[pick]]);
          flitNext[pick]++;
        end
        pktNext[pick]++;
        cur = pick;
      end
    end
  endfunction

  task automatic sendPort(input int p);
    logic [flitWidth-1:0] flit;
    logic accepted;
    for (int i = 0; i < portFlits[p].size(); i++)
    begin
      flit = portFlits[p][i];
      inValid[p] <= 1'b1;
      inFlitId[p] <= flit[flitWidth-1 -: nocPkg::flitIdWidth];
      inPayload[p] <= flit[nocPkg::payloadWidth-1:0];
      accepted = 1'b0;
      while (!accepted)
      begin
        @(negedge clk);
        accepted = inReady[p]; // Not full here means the next edge takes the flit
        @(posedge clk);
      end
    end
    inValid[p] <= 1'b0;
  endtask

  task automatic runBatch(input bit stall);
    int waited;
    int limit;
    predictOrder();
    limit = 20 * expQ.size() + 20;
    @(posedge clk);
    sawFull = '0;
    fork
      sendPort(0);
      sendPort(1);
      sendPort(2);
      sendPort(3);
      sendPort(4);
      begin
        outReady <= 1'b0;
        repeat (queueDepth + 2) @(posedge clk); // Preload the queues
        waited = 0;
        while (expQ.size() != 0 && waited < limit)
        begin
          outReady <= stall ? (randBits(2) != 0) : 1'b1;
          @(posedge clk);
          waited++;
        end
        outReady <= 1'b1;
      end
    join
    repeat (4) @(posedge clk); // Arbiter back to idle
    assert (expQ.size() == 0)
      else
      begin
        $display("%0d expected flits never reached the output link", expQ.size());
        errors++;
        expQ.delete();
      end
    for (int p = 0; p < nocPkg::numPorts; p++)
    begin
      portFlits[p].delete();
      pktLens[p].delete();
    end
  endtask

  task automatic finishTest(input string name);
    testCount++;
    if (errors == errorsBefore)
      $display("test %0d %s: passed", testCount, name);
    else
    begin
      failedTests++;
      $display("test %0d %s: failed with %0d errors", testCount, name, errors - errorsBefore);
    end
    errorsBefore = errors;
  endtask

  always @(negedge clk)
  begin
    if (!rst)
    begin
      sawFull = sawFull | (inValid & ~inReady);
      if (outValid && outReady)
      begin
        assert (expQ.size() != 0)
          else
          begin
            $display("extra flit on the output link, id %h payload %h", outFlitId, outPayload);
            errors++;
          end
        if (expQ.size() != 0)
        begin
          expected = expQ.pop_front();
          assert (outFlitId == expected[flitWidth-1 -: nocPkg::flitIdWidth])
            else
            begin
              $display("error outFlitId: got %h, expected %h", outFlitId,
                       expected[flitWidth-1 -: nocPkg::flitIdWidth]);
              errors++;
            end
          assert (outPayload == expected[nocPkg::payloadWidth-1:0])
            else
            begin
              $display("error outPayload: got %h, expected %h", outPayload,
                       expected[nocPkg::payloadWidth-1:0]);
              errors++;
            end
          if (outFlitId == nocPkg::headerId)
            lastHeaderLen = outPayload[nocPkg::lengthWidth-1:0];
          flitsChecked++;
        end
      end
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > 20 * flitsSent + 200)
    begin
      $display("timeout after %0d cycles, the run stopped making progress", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  initial
  begin
    inValid = '0;
    inFlitId = '0;
    inPayload = '0;
    outReady = 1'b0;
    wait (rst === 1'b0);
    @(negedge clk);
    assert (!outValid)
      else
      begin
        $display("error outValid: got %h, expected %h", outValid, 1'b0);
        errors++;
      end
    assert (inReady == '1)
      else
      begin
        $display("error inReady: got %h, expected %h", inReady, {nocPkg::numPorts{1'b1}});
        errors++;
      end
    finishTest("after reset");

    expLen = 1 + randBits(2);
    addPacket(nocPkg::portE, expLen);
    runBatch(1'b0);
    assert (lastHeaderLen == nocPkg::lengthWidth'(expLen))
      else
      begin
        $display("error outPayload length: got %h, expected %h", lastHeaderLen, expLen);
        errors++;
      end
    finishTest("single packet");

    for (int p = 0; p < nocPkg::numPorts; p++)
      addPacket(p, 1 + randBits(2));
    runBatch(1'b0);
    finishTest("full rotation");

    addPacket(nocPkg::portN, 1 + randBits(2));
    addPacket(nocPkg::portN, 1 + randBits(2));
    addPacket(nocPkg::portW, 1 + randBits(2));
    runBatch(1'b0);
    finishTest("packet hold and release");

    addPacket(nocPkg::portS, 4);
    addPacket(nocPkg::portS, 3); // More than the queue can hold
    for (int p = 0; p < nocPkg::portS; p++)
      addPacket(p, 1 + randBits(2));
    runBatch(1'b1);
    assert (sawFull[nocPkg::portS])
      else
      begin
        $display("port S queue never filled, inReady stayed high");
        errors++;
      end
    finishTest("back-pressure");

    for (int b = 0; b < 4; b++)
    begin
      for (int p = 0; p < nocPkg::numPorts; p++)
        repeat (randBits(2)) addPacket(p, 1 + randBits(2));
      runBatch(1'b1);
    end
    finishTest("random mix");

    $display("%0d tests, %0d failed, %0d flits checked, %0d errors", testCount, failedTests,
             flitsChecked, errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- tests/clockGen.sv
`timescale 1ns/10ps

module clockGen (
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk; // 100 ns period
  end

  initial
  begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

//--- design/flitSwitch.sv
`timescale 1ns/10ps

module flitSwitch #(
  parameter int queueDepth = 4
) (
  input  logic                                                 clk,
  input  logic                                                 rst,
  input  logic [nocPkg::numPorts-1:0]                          inValid,
  input  logic [nocPkg::numPorts-1:0][nocPkg::flitIdWidth-1:0] inFlitId,
  input  logic [nocPkg::numPorts-1:0][nocPkg::payloadWidth-1:0] inPayload,
  output logic [nocPkg::numPorts-1:0]                          inReady,
  output logic                                                 outValid,
  output logic [nocPkg::flitIdWidth-1:0]                       outFlitId,
  output logic [nocPkg::payloadWidth-1:0]                      outPayload,
  input  logic                                                 outReady
);

  logic [nocPkg::numPorts-1:0]                           headValid;
  logic [nocPkg::numPorts-1:0][nocPkg::flitIdWidth-1:0]  headFlitId;
  logic [nocPkg::numPorts-1:0][nocPkg::payloadWidth-1:0] headPayload;
  logic [nocPkg::numPorts-1:0]                           grant;
  logic [nocPkg::numPorts-1:0]                           pop;
  logic [nocPkg::numPorts-1:0]                           timesUp;

  for (genvar p = 0; p < nocPkg::numPorts; p++)
  begin : gPort
    flitQueue #(
      .queueDepth (queueDepth)
    ) u_flitQueue (
      .clk         (clk),
      .rst         (rst),
      .inValid     (inValid[p]),
      .inFlitId    (inFlitId[p]),
      .inPayload   (inPayload[p]),
      .inReady     (inReady[p]),
      .headValid   (headValid[p]),
      .headFlitId  (headFlitId[p]),
      .headPayload (headPayload[p]),
      .pop         (pop[p])
    );

    holdTimer u_holdTimer (
      .clk         (clk),
      .rst         (rst),
      .granted     (grant[p]),
      .pop         (pop[p]),
      .headFlitId  (headFlitId[p]),
      .headPayload (headPayload[p]),
      .timesUp     (timesUp[p])
    );
  end

  grantArbiter u_grantArbiter (
    .clk     (clk),
    .rst     (rst),
    .request (headValid), // Any queued flit requests the link
    .timesUp (timesUp),
    .grant   (grant)
  );

  outputMux u_outputMux (
    .grant       (grant),
    .headValid   (headValid),
    .headFlitId  (headFlitId),
    .headPayload (headPayload),
    .outReady    (outReady),
    .outValid    (outValid),
    .outFlitId   (outFlitId),
    .outPayload  (outPayload),
    .pop         (pop)
  );

endmodule

//--- design/outputMux.sv
`timescale 1ns/10ps

module outputMux (
  input  logic [nocPkg::numPorts-1:0]                          grant,
  input  logic [nocPkg::numPorts-1:0]                          headValid,
  input  logic [nocPkg::numPorts-1:0][nocPkg::flitIdWidth-1:0] headFlitId,
  input  logic [nocPkg::numPorts-1:0][nocPkg::payloadWidth-1:0] headPayload,
  input  logic                                                 outReady,
  output logic                                                 outValid,
  output logic [nocPkg::flitIdWidth-1:0]                       outFlitId,
  output logic [nocPkg::payloadWidth-1:0]                      outPayload,
  output logic [nocPkg::numPorts-1:0]                          pop
);

  logic [nocPkg::numPorts-1:0] live;

  assign live = grant & headValid;
  assign outValid = |live;
  assign pop = live & {nocPkg::numPorts{outReady}}; // Transfer pops the granted queue

  // AND-OR select that relies on a one-hot grant
  always_comb
  begin
    outFlitId = '0;
    outPayload = '0;
    for (int p = 0; p < nocPkg::numPorts; p++)
    begin
      if (grant[p])
      begin
        outFlitId = outFlitId | headFlitId[p];
        outPayload = outPayload | headPayload[p];
      end
    end
  end

  always_comb
  begin
    if (outValid)
      grantOneHot: assert #0 ($onehot(grant))
        else $error("outputMux valid with grant %b", grant);
  end

endmodule

//--- design/holdTimer.sv
`timescale 1ns/10ps

module holdTimer (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           granted,
  input  logic                           pop,
  input  logic [nocPkg::flitIdWidth-1:0] headFlitId,
  input  nocPkg::flitPayload             headPayload,
  output logic                           timesUp
);

  logic [nocPkg::lengthWidth-1:0] count;
  logic [nocPkg::lengthWidth-1:0] length;

  always_ff @(posedge clk)
  begin
    if (rst || !granted)
    begin
      count <= '0;
      length <= '0;
    end
    else if (pop)
    begin
      if (headFlitId == nocPkg::headerId)
      begin
        length <= headPayload.header.length;
        count <= nocPkg::lengthWidth'(1); // Header is the first flit
      end
      else if (headFlitId == nocPkg::bodyId)
        count <= count + 1'b1;
    end
  end

  // Zero length means no header seen yet
  assign timesUp = (count == length) && (length != '0);

  popOnlyGranted: assert property (@(posedge clk) disable iff (rst) pop |-> granted)
    else $error("holdTimer pop without grant");

endmodule

//--- design/grantArbiter.sv
`timescale 1ns/10ps

module grantArbiter (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [nocPkg::numPorts-1:0] request,
  input  logic [nocPkg::numPorts-1:0] timesUp,
  output logic [nocPkg::numPorts-1:0] grant
);

  // One-hot states with idle in bit 0 and port p in bit p+1
  localparam logic [5:0] stIdle = 6'b000001;
  localparam logic [5:0] stL = 6'b000010;
  localparam logic [5:0] stN = 6'b000100;
  localparam logic [5:0] stE = 6'b001000;
  localparam logic [5:0] stW = 6'b010000;
  localparam logic [5:0] stS = 6'b100000;

  logic [5:0] state;
  logic [5:0] nextState;

  // First requester from port first onward with wraparound
  function automatic logic [5:0] rotate(input logic [nocPkg::numPorts-1:0] req,
                                        input int first);
    logic [5:0] pick;
    int idx;
    pick = stIdle;
    for (int k = nocPkg::numPorts - 1; k >= 0; k--)
    begin
      idx = (first + k) % nocPkg::numPorts;
      if (req[idx])
        pick = stL << idx; // Lower offset overrides so nearest wins
    end
    return pick;
  endfunction

  function automatic logic [5:0] holdOrRotate(input logic [nocPkg::numPorts-1:0] req,
                                              input logic [nocPkg::numPorts-1:0] up,
                                              input int cur);
    if (req[cur] && !up[cur])
      return stL << cur;
    return rotate(req, (cur + 1) % nocPkg::numPorts); // Holder is searched last
  endfunction

  always_comb
  begin
    case (state)
      stIdle: nextState = rotate(request, nocPkg::portL);
      stL: nextState = holdOrRotate(request, timesUp, nocPkg::portL);
      stN: nextState = holdOrRotate(request, timesUp, nocPkg::portN);
      stE: nextState = holdOrRotate(request, timesUp, nocPkg::portE);
      stW: nextState = holdOrRotate(request, timesUp, nocPkg::portW);
      stS: nextState = holdOrRotate(request, timesUp, nocPkg::portS);
      default: nextState = stIdle;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= stIdle;
    else
      state <= nextState;
  end

  // A finished packet blocks its port until the state has moved on,
  // otherwise the next header would slip out in the gap cycle
  assign grant = state[5:1] & ~timesUp;

  stateOneHot: assert property (@(posedge clk) disable iff (rst) $onehot(state))
    else $error("grantArbiter state not one-hot: %b", state);

endmodule

//--- design/flitQueue.sv
`timescale 1ns/10ps

module flitQueue #(
  parameter int queueDepth = 4
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           inValid,
  input  logic [nocPkg::flitIdWidth-1:0] inFlitId,
  input  nocPkg::flitPayload             inPayload,
  output logic                           inReady,
  output logic                           headValid,
  output logic [nocPkg::flitIdWidth-1:0] headFlitId,
  output nocPkg::flitPayload             headPayload,
  input  logic                           pop
);

  localparam int ptrWidth = (queueDepth > 1) ? $clog2(queueDepth) : 1;
  localparam int cntWidth = $clog2(queueDepth + 1);

  logic [nocPkg::flitIdWidth-1:0] idMem [queueDepth];
  nocPkg::flitPayload             payloadMem [queueDepth];
  logic [ptrWidth-1:0]            wrPtr;
  logic [ptrWidth-1:0]            rdPtr;
  logic [cntWidth-1:0]            count;
  logic                           push;

  function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
    if (ptr == ptrWidth'(queueDepth - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign inReady = (count != cntWidth'(queueDepth)); // Ready while not full
  assign push = inValid && inReady;
  assign headValid = (count != '0);
  assign headFlitId = idMem[rdPtr];
  assign headPayload = payloadMem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      idMem[wrPtr] <= inFlitId;
      payloadMem[wrPtr] <= inPayload;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= nextPtr(wrPtr);
      if (pop)
        rdPtr <= nextPtr(rdPtr);
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1; // Push with pop leaves the count alone
    end
  end

  popNotEmpty: assert property (@(posedge clk) disable iff (rst) pop |-> headValid)
    else $error("flitQueue popped while empty");

endmodule

//--- design/nocPkg.sv
package nocPkg;

  parameter int numPorts = 5;
  parameter int flitIdWidth = 3;
  parameter int payloadWidth = 12;
  parameter int lengthWidth = 8;

  // Flit id codes
  parameter logic [flitIdWidth-1:0] headerId = 3'd1;
  parameter logic [flitIdWidth-1:0] bodyId = 3'd2;

  // Port indices in rotation order
  parameter int portL = 0;
  parameter int portN = 1;
  parameter int portE = 2;
  parameter int portW = 3;
  parameter int portS = 4;

  typedef struct packed {
    logic [payloadWidth-lengthWidth-1:0] destTag; // Routing tag passed through untouched
    logic [lengthWidth-1:0] length;               // Packet length in flits, header included
  } headerFields;

  // Header flits carry the fields above, body flits carry plain data
  typedef union packed {
    headerFields header;
    logic [payloadWidth-1:0] data;
  } flitPayload;

endpackage
